// File: include/vid_params.svh
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

// ==========================================================================
// Raster geometry
// ==========================================================================

// Horizontal timing in pixel clocks
`define VID_H_ACTIVE 16
`define VID_H_FRONT 2
`define VID_H_SYNC 3
`define VID_H_BACK 3
`define VID_H_TOTAL (`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)

// Vertical timing in lines
`define VID_V_ACTIVE 8
`define VID_V_FRONT 1
`define VID_V_SYNC 2
`define VID_V_BACK 1
`define VID_V_TOTAL (`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

// Buffer depth, one word per active pixel
`define VID_FRAME_WORDS (`VID_H_ACTIVE * `VID_V_ACTIVE)

// ==========================================================================
// Channel widths
// ==========================================================================
`define VID_CAM_BITS 12
`define VID_PACK_BITS 5
`define VID_MONO_BITS 8
`define VID_VGA_BITS 8
`define VID_WORD_BITS 16

// Frame-rate window in clocks, count width of the meter
`define VID_RATE_WINDOW 400
`define VID_RATE_BITS 8

`endif

// File: src/vid_pkg.sv
`default_nettype none

`include "vid_params.svh"

// ==========================================================================
// Shared video types
// ==========================================================================
package vid_pkg;

  // Source shown on the display
  // Binary, eroded and dilated are all mono byte streams
  typedef enum logic [1:0] {
    view_rgb     = 2'd0,
    view_binary  = 2'd1,
    view_eroded  = 2'd2,
    view_dilated = 2'd3
  } view_t;

  // Buffer word layout
  // RGB  -> {1'b0, r[4:0], g[4:0], b[4:0]}
  // Mono -> {8'h00, mono[7:0]}
  typedef logic [`VID_WORD_BITS-1:0] buf_word_t;

  // One address per active pixel
  typedef logic [$clog2(`VID_FRAME_WORDS)-1:0] buf_addr_t;

endpackage

`default_nettype wire

// File: src/vid_raster_if.sv
`default_nettype none

// ==========================================================================
// Raster control bundle
// ==========================================================================
interface vid_raster_if;

  // Active-low syncs
  logic hsync;
  logic vsync;
  // Active-low blank, high during visible pixels
  logic blank_n;
  // High exactly on active pixels, paces the buffer read
  logic disp_ena;

  // Stage that produces the raster
  modport source (
    output hsync,
    output vsync,
    output blank_n,
    output disp_ena
  );

  // Stage that follows it
  modport sink (
    input hsync,
    input vsync,
    input blank_n,
    input disp_ena
  );

endinterface

`default_nettype wire

// File: src/stream_pack.sv
`default_nettype none

`include "vid_params.svh"

module stream_pack (
  input  wire                      ccd_pixel_clk,
  input  wire                      rst_n,
  input  wire                      stream_reset_n,
  input  vid_pkg::view_t           view_sel,
  input  wire [`VID_CAM_BITS-1:0]  rgb_red,
  input  wire [`VID_CAM_BITS-1:0]  rgb_green,
  input  wire [`VID_CAM_BITS-1:0]  rgb_blue,
  input  wire                      rgb_valid,
  input  wire [`VID_MONO_BITS-1:0] binarized,
  input  wire                      bin_valid,
  input  wire [`VID_MONO_BITS-1:0] eroded,
  input  wire                      erosion_valid,
  input  wire [`VID_MONO_BITS-1:0] dilated,
  input  wire                      dilation_valid,
  output vid_pkg::buf_word_t       wr_word,
  output logic                     wr_stb
);
  import vid_pkg::*;

  localparam int MONO_PAD = `VID_WORD_BITS - `VID_MONO_BITS;

  buf_word_t sel_word;
  logic      sel_valid;

  // Source mux
  // Only the chosen stream's strobe reaches the buffer
  always_comb begin
    case (view_sel)
      view_rgb: begin
        // Top bits of each channel, MSB left at zero
        sel_word  = {1'b0,
                     rgb_red[`VID_CAM_BITS-1 -: `VID_PACK_BITS],
                     rgb_green[`VID_CAM_BITS-1 -: `VID_PACK_BITS],
                     rgb_blue[`VID_CAM_BITS-1 -: `VID_PACK_BITS]};
        sel_valid = rgb_valid;
      end
      view_binary: begin
        sel_word  = {{MONO_PAD{1'b0}}, binarized};
        sel_valid = bin_valid;
      end
      view_eroded: begin
        sel_word  = {{MONO_PAD{1'b0}}, eroded};
        sel_valid = erosion_valid;
      end
      default: begin
        sel_word  = {{MONO_PAD{1'b0}}, dilated};
        sel_valid = dilation_valid;
      end
    endcase
  end

  // Strobe register, held off during a stream reset
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_stb <= 1'b0;
    end else begin
      wr_stb <= sel_valid & stream_reset_n;
    end
  end

  // Payload follows the strobe by the same cycle
  always_ff @(posedge ccd_pixel_clk) begin
    wr_word <= sel_word;
  end

endmodule

`default_nettype wire

// File: src/frame_buffer.sv
`default_nettype none

`include "vid_params.svh"

module frame_buffer (
  input  wire                ccd_pixel_clk,
  input  wire                rst_n,
  input  wire                stream_reset_n,
  input  vid_pkg::buf_word_t wr_word,
  input  wire                wr_stb,
  vid_raster_if.sink         raster_in,
  vid_raster_if.source       raster_out,
  output vid_pkg::buf_word_t rd_word
);
  import vid_pkg::*;

  localparam buf_addr_t LAST_ADDR = buf_addr_t'(`VID_FRAME_WORDS - 1);

  // ==========================================================================
  // Storage and address counters
  // ==========================================================================

  // One frame of packed pixels
  buf_word_t mem [`VID_FRAME_WORDS];

  buf_addr_t wr_addr;
  buf_addr_t rd_addr;
  logic      wr_en;

  // No writes while the stream is held in reset
  assign wr_en = wr_stb & stream_reset_n;

  // Write pointer, wraps at the end of the frame
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (!stream_reset_n) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      wr_addr <= (wr_addr == LAST_ADDR) ? '0 : wr_addr + 1'b1;
    end
  end

  // Read pointer
  // One step per active pixel, so a full frame reads every word once
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (!stream_reset_n) begin
      rd_addr <= '0;
    end else if (raster_in.disp_ena) begin
      rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;
    end
  end

  // Memory write port
  always_ff @(posedge ccd_pixel_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // Registered read port
  // Same-address collision returns the word stored before this edge
  always_ff @(posedge ccd_pixel_clk) begin
    if (raster_in.disp_ena) begin
      rd_word <= mem[rd_addr];
    end
  end

  // ==========================================================================
  // Raster delay, keeps controls in step with rd_word
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      raster_out.hsync    <= 1'b1;
      raster_out.vsync    <= 1'b1;
      raster_out.blank_n  <= 1'b0;
      raster_out.disp_ena <= 1'b0;
    end else begin
      raster_out.hsync    <= raster_in.hsync;
      raster_out.vsync    <= raster_in.vsync;
      raster_out.blank_n  <= raster_in.blank_n;
      raster_out.disp_ena <= raster_in.disp_ena;
    end
  end

endmodule

`default_nettype wire

// File: src/vga_timing.sv
`default_nettype none

`include "vid_params.svh"

module vga_timing (
  input  wire          ccd_pixel_clk,
  input  wire          rst_n,
  vid_raster_if.source raster
);

  localparam int HW = $clog2(`VID_H_TOTAL);
  localparam int VW = $clog2(`VID_V_TOTAL);

  // Line layout: active, front porch, sync, back porch
  localparam logic [HW-1:0] H_LAST       = HW'(`VID_H_TOTAL - 1);
  localparam logic [HW-1:0] H_ACT_END    = HW'(`VID_H_ACTIVE);
  localparam logic [HW-1:0] H_SYNC_START = HW'(`VID_H_ACTIVE + `VID_H_FRONT);
  localparam logic [HW-1:0] H_SYNC_END   = HW'(`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC);

  // Frame layout, counted in whole lines
  localparam logic [VW-1:0] V_LAST       = VW'(`VID_V_TOTAL - 1);
  localparam logic [VW-1:0] V_ACT_END    = VW'(`VID_V_ACTIVE);
  localparam logic [VW-1:0] V_SYNC_START = VW'(`VID_V_ACTIVE + `VID_V_FRONT);
  localparam logic [VW-1:0] V_SYNC_END   = VW'(`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC);

  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          h_wrap;
  logic          h_active;
  logic          v_active;

  assign h_wrap = (h_cnt == H_LAST);

  // ==========================================================================
  // Position counters
  // ==========================================================================

  // Pixel within the line
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_wrap ? '0 : h_cnt + 1'b1;
    end
  end

  // Line within the frame, steps at end of line
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      v_cnt <= '0;
    end else if (h_wrap) begin
      v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // Decode
  // ==========================================================================
  assign h_active = (h_cnt < H_ACT_END);
  assign v_active = (v_cnt < V_ACT_END);

  // Syncs low for their full count after the front porch
  assign raster.hsync = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
  assign raster.vsync = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

  // Visible area
  assign raster.disp_ena = h_active & v_active;
  assign raster.blank_n  = h_active & v_active;

endmodule

`default_nettype wire

// File: src/vga_pixel_out.sv
`default_nettype none

`include "vid_params.svh"

module vga_pixel_out (
  input  wire                      ccd_pixel_clk,
  input  wire                      rst_n,
  input  vid_pkg::view_t           view_sel,
  input  wire [2:0]                chan_en,
  input  vid_pkg::buf_word_t       rd_word,
  vid_raster_if.sink               raster,
  output logic [`VID_VGA_BITS-1:0] vga_r,
  output logic [`VID_VGA_BITS-1:0] vga_g,
  output logic [`VID_VGA_BITS-1:0] vga_b,
  output logic                     vga_hs,
  output logic                     vga_vs,
  output logic                     vga_blank_n
);
  import vid_pkg::*;

  localparam int P = `VID_PACK_BITS;

  logic [`VID_VGA_BITS-1:0] r_nxt;
  logic [`VID_VGA_BITS-1:0] g_nxt;
  logic [`VID_VGA_BITS-1:0] b_nxt;

  // Five-bit field to display width, low bits zero
  function automatic logic [`VID_VGA_BITS-1:0] chan_expand(
    input logic [P-1:0] field,
    input logic         en
  );
    chan_expand = en ? {field, {(`VID_VGA_BITS - P){1'b0}}} : '0;
  endfunction

  // Colour select
  // chan_en bit 0 red, bit 1 green, bit 2 blue
  always_comb begin
    if (!raster.disp_ena) begin
      r_nxt = '0;
      g_nxt = '0;
      b_nxt = '0;
    end else if (view_sel == view_rgb) begin
      r_nxt = chan_expand(rd_word[3*P-1 -: P], chan_en[0]);
      g_nxt = chan_expand(rd_word[2*P-1 -: P], chan_en[1]);
      b_nxt = chan_expand(rd_word[P-1 -: P], chan_en[2]);
    end else begin
      // Mono, grey on all three guns
      r_nxt = rd_word[`VID_MONO_BITS-1:0];
      g_nxt = rd_word[`VID_MONO_BITS-1:0];
      b_nxt = rd_word[`VID_MONO_BITS-1:0];
    end
  end

  // Pin register, second stage after the raster counters
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
      vga_hs      <= 1'b1;
      vga_vs      <= 1'b1;
      vga_blank_n <= 1'b0;
    end else begin
      vga_r       <= r_nxt;
      vga_g       <= g_nxt;
      vga_b       <= b_nxt;
      vga_hs      <= raster.hsync;
      vga_vs      <= raster.vsync;
      vga_blank_n <= raster.blank_n;
    end
  end

endmodule

`default_nettype wire

// File: src/frame_rate_meter.sv
`default_nettype none

`include "vid_params.svh"

module frame_rate_meter (
  input  wire        ccd_pixel_clk,
  input  wire        rst_n,
  input  wire        frame_start,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic       pulse_led
);

  localparam int WIN_W = $clog2(`VID_RATE_WINDOW);
  localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`VID_RATE_WINDOW - 1);

  logic [WIN_W-1:0]          win_cnt;
  logic                      win_end;
  logic [`VID_RATE_BITS-1:0] frame_cnt;
  logic [`VID_RATE_BITS-1:0] cnt_nxt;

  // Active-low segments, bit 6 is g, bit 0 is a
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'b1000000;
      4'h1: seg7 = 7'b1111001;
      4'h2: seg7 = 7'b0100100;
      4'h3: seg7 = 7'b0110000;
      4'h4: seg7 = 7'b0011001;
      4'h5: seg7 = 7'b0010010;
      4'h6: seg7 = 7'b0000010;
      4'h7: seg7 = 7'b1111000;
      4'h8: seg7 = 7'b0000000;
      4'h9: seg7 = 7'b0010000;
      4'ha: seg7 = 7'b0001000;
      4'hb: seg7 = 7'b0000011;
      4'hc: seg7 = 7'b1000110;
      4'hd: seg7 = 7'b0100001;
      4'he: seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  assign win_end = (win_cnt == WIN_LAST);

  // Saturating count, includes a strobe on the last window cycle
  assign cnt_nxt = (frame_start && !(&frame_cnt)) ? frame_cnt + 1'b1 : frame_cnt;

  // Window timer and frame counter
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt   <= '0;
      frame_cnt <= '0;
    end else begin
      win_cnt   <= win_end ? '0 : win_cnt + 1'b1;
      frame_cnt <= win_end ? '0 : cnt_nxt;
    end
  end

  // Display and LED, loaded as the timer returns to zero
  always_ff @(posedge ccd_pixel_clk or negedge rst_n) begin
    if (!rst_n) begin
      hex0      <= seg7(4'h0);
      hex1      <= seg7(4'h0);
      pulse_led <= 1'b0;
    end else if (win_end) begin
      hex0      <= seg7(cnt_nxt[3:0]);
      hex1      <= seg7(cnt_nxt[7:4]);
      pulse_led <= ~pulse_led;
    end
  end

endmodule

`default_nettype wire

// File: src/vid_capture_top.sv
`default_nettype none

`include "vid_params.svh"

module vid_capture_top (
  input  wire                       ccd_pixel_clk,
  input  wire                       rst_n,
  input  wire                       stream_reset_n,
  input  vid_pkg::view_t            view_sel,
  input  wire [2:0]                 chan_en,
  input  wire [`VID_CAM_BITS-1:0]   rgb_red,
  input  wire [`VID_CAM_BITS-1:0]   rgb_green,
  input  wire [`VID_CAM_BITS-1:0]   rgb_blue,
  input  wire                       rgb_valid,
  input  wire [`VID_MONO_BITS-1:0]  binarized,
  input  wire                       bin_valid,
  input  wire [`VID_MONO_BITS-1:0]  eroded,
  input  wire                       erosion_valid,
  input  wire [`VID_MONO_BITS-1:0]  dilated,
  input  wire                       dilation_valid,
  input  wire                       frame_start,
  output wire [`VID_VGA_BITS-1:0]   vga_r,
  output wire [`VID_VGA_BITS-1:0]   vga_g,
  output wire [`VID_VGA_BITS-1:0]   vga_b,
  output wire                       vga_hs,
  output wire                       vga_vs,
  output wire                       vga_blank_n,
  output wire [6:0]                 hex0,
  output wire [6:0]                 hex1,
  output wire                       pulse_led
);
  import vid_pkg::*;

  // ==========================================================================
  // Write side
  // ==========================================================================
  buf_word_t wr_word;
  logic      wr_stb;
  buf_word_t rd_word;

  // Raster straight from the counters, then one cycle later
  vid_raster_if raster_gen ();
  vid_raster_if raster_buf ();

  stream_pack u_pack (
    .ccd_pixel_clk  (ccd_pixel_clk),
    .rst_n          (rst_n),
    .stream_reset_n (stream_reset_n),
    .view_sel       (view_sel),
    .rgb_red        (rgb_red),
    .rgb_green      (rgb_green),
    .rgb_blue       (rgb_blue),
    .rgb_valid      (rgb_valid),
    .binarized      (binarized),
    .bin_valid      (bin_valid),
    .eroded         (eroded),
    .erosion_valid  (erosion_valid),
    .dilated        (dilated),
    .dilation_valid (dilation_valid),
    .wr_word        (wr_word),
    .wr_stb         (wr_stb)
  );

  frame_buffer u_fbuf (
    .ccd_pixel_clk  (ccd_pixel_clk),
    .rst_n          (rst_n),
    .stream_reset_n (stream_reset_n),
    .wr_word        (wr_word),
    .wr_stb         (wr_stb),
    .raster_in      (raster_gen.sink),
    .raster_out     (raster_buf.source),
    .rd_word        (rd_word)
  );

  // ==========================================================================
  // Display side
  // ==========================================================================
  vga_timing u_timing (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .raster        (raster_gen.source)
  );

  vga_pixel_out u_pix (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .view_sel      (view_sel),
    .chan_en       (chan_en),
    .rd_word       (rd_word),
    .raster        (raster_buf.sink),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .vga_hs        (vga_hs),
    .vga_vs        (vga_vs),
    .vga_blank_n   (vga_blank_n)
  );

  // Camera frame rate on two digits
  frame_rate_meter u_rate (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst_n         (rst_n),
    .frame_start   (frame_start),
    .hex0          (hex0),
    .hex1          (hex1),
    .pulse_led     (pulse_led)
  );

endmodule

`default_nettype wire

// File: sim/tb_vid_capture.sv
`default_nettype none

`include "vid_params.svh"

module tb_vid_capture;
  import vid_pkg::*;

  localparam int H_TOTAL      = `VID_H_TOTAL;
  localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
  localparam int WORDS        = `VID_FRAME_WORDS;
  localparam int LIMIT_CYCLES = 6 * FRAME_CYCLES + 3 * `VID_RATE_WINDOW;
  localparam int NUM_TESTS    = 6;
  localparam int RATE_STROBES = 37;
  localparam int PRE_WORDS    = 5;

  logic ccd_pixel_clk = 1'b0;
  logic rst_n, stream_reset_n, rgb_valid, bin_valid, erosion_valid, dilation_valid;
  logic frame_start;
  view_t view_sel;
  logic [2:0] chan_en;
  logic [`VID_CAM_BITS-1:0] rgb_red, rgb_green, rgb_blue;
  logic [`VID_MONO_BITS-1:0] binarized, eroded, dilated;
  wire [`VID_VGA_BITS-1:0] vga_r, vga_g, vga_b;
  wire vga_hs, vga_vs, vga_blank_n, pulse_led;
  wire [6:0] hex0, hex1;

  // Reference model state
  buf_word_t ref_mem [WORDS];
  buf_word_t cur_word;
  buf_addr_t model_rd;
  int model_wr;
  logic model_clr;
  logic [`VID_VGA_BITS-1:0] exp_r, exp_g, exp_b;
  logic [31:0] lcg_state;
  logic check_en;
  int pix_test;
  int test_err [NUM_TESTS];
  string tname [NUM_TESTS] = '{"reset_state", "raster_geometry", "rgb_view",
                               "mono_views", "stream_reset", "frame_rate"};

  vid_capture_top UUT (.*);

  always #(20) ccd_pixel_clk = ~ccd_pixel_clk;

  // ==========================================================================
  // Model
  // ==========================================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Active-low hex digit table, segment a in bit 0
  function automatic logic [6:0] seg_of(input logic [3:0] n);
    logic [6:0] tbl [16];
    tbl = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
            7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
    return tbl[n];
  endfunction

  // Read pointer follows the displayed pixels
  always @(posedge ccd_pixel_clk) begin
    if (!rst_n || model_clr) begin
      model_rd <= '0;
    end else if (vga_blank_n) begin
      model_rd <= (model_rd == buf_addr_t'(WORDS - 1)) ? '0 : model_rd + 1'b1;
    end
  end

  // Expected colour for the word now on the pins
  always_comb begin
    cur_word = ref_mem[model_rd];
    if (view_sel == view_rgb) begin
      exp_r = chan_en[0] ? {cur_word[14:10], 3'b000} : 8'h00;
      exp_g = chan_en[1] ? {cur_word[9:5], 3'b000} : 8'h00;
      exp_b = chan_en[2] ? {cur_word[4:0], 3'b000} : 8'h00;
    end else begin
      exp_r = cur_word[7:0];
      exp_g = cur_word[7:0];
      exp_b = cur_word[7:0];
    end
  end

  // ==========================================================================
  // Assertions
  // ==========================================================================
  a_pixel: assert property (@(posedge ccd_pixel_clk) disable iff (!rst_n)
    (check_en && vga_blank_n) |-> (vga_r == exp_r && vga_g == exp_g && vga_b == exp_b))
    else begin
      test_err[pix_test]++;
      $display("error: %s expected %h %h %h actual %h %h %h", tname[pix_test],
               $sampled(exp_r), $sampled(exp_g), $sampled(exp_b),
               $sampled(vga_r), $sampled(vga_g), $sampled(vga_b));
    end

  // Line period and sync widths
  a_hs_period: assert property (@(posedge ccd_pixel_clk) disable iff (!rst_n)
    $fell(vga_hs) |-> ##(H_TOTAL) $fell(vga_hs))
    else begin
      test_err[1]++;
      $display("raster_geometry: hsync period is wrong");
    end
  a_hs_width: assert property (@(posedge ccd_pixel_clk) disable iff (!rst_n)
    $fell(vga_hs) |-> ##(`VID_H_SYNC) $rose(vga_hs))
    else begin
      test_err[1]++;
      $display("raster_geometry: hsync width is wrong");
    end
  a_blank_width: assert property (@(posedge ccd_pixel_clk) disable iff (!rst_n)
    $rose(vga_blank_n) |-> ##(`VID_H_ACTIVE) $fell(vga_blank_n))
    else begin
      test_err[1]++;
      $display("raster_geometry: active line length is wrong");
    end
  a_vs_width: assert property (@(posedge ccd_pixel_clk) disable iff (!rst_n)
    $fell(vga_vs) |-> ##(`VID_V_SYNC * H_TOTAL) $rose(vga_vs))
    else begin
      test_err[1]++;
      $display("raster_geometry: vsync width is wrong");
    end

  // ==========================================================================
  // Tasks
  // ==========================================================================
  task automatic check_eq(input int id, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      test_err[id]++;
      $display("error: %s expected %h actual %h", tname[id], exp, act);
    end
  endtask

  task automatic report_test(input int id);
    $display("test %s: %s, %0d errors", tname[id], (test_err[id] == 0) ? "ok" : "failed",
             test_err[id]);
  endtask

  task automatic wait_vs_fall();
    logic prev;
    prev = vga_vs;
    @(negedge ccd_pixel_clk);
    while (!(prev && !vga_vs)) begin
      prev = vga_vs;
      @(negedge ccd_pixel_clk);
    end
  endtask

  // One frame of strobes on the selected source
  // With noise, every word follows a cycle that strobes only the other sources
  task automatic write_frame(input view_t v, input logic noise);
    for (int i = 0; i < WORDS; i++) begin
      if (noise) begin
        @(negedge ccd_pixel_clk);
        rgb_valid      = (v != view_rgb);
        bin_valid      = (v != view_binary);
        erosion_valid  = (v != view_eroded);
        dilation_valid = (v != view_dilated);
      end
      @(negedge ccd_pixel_clk);
      lcg_state = lcg_next(lcg_state);
      rgb_red   = lcg_state[27:16];
      lcg_state = lcg_next(lcg_state);
      rgb_green = lcg_state[27:16];
      lcg_state = lcg_next(lcg_state);
      rgb_blue  = lcg_state[27:16];
      binarized = lcg_state[31:24];
      eroded    = lcg_state[23:16];
      dilated   = lcg_state[15:8];
      rgb_valid      = (v == view_rgb);
      bin_valid      = (v == view_binary);
      erosion_valid  = (v == view_eroded);
      dilation_valid = (v == view_dilated);
      case (v)
        view_rgb:     ref_mem[model_wr] = {1'b0, rgb_red[11:7], rgb_green[11:7], rgb_blue[11:7]};
        view_binary:  ref_mem[model_wr] = {8'h00, binarized};
        view_eroded:  ref_mem[model_wr] = {8'h00, eroded};
        default:      ref_mem[model_wr] = {8'h00, dilated};
      endcase
      model_wr = (model_wr + 1) % WORDS;
    end
    @(negedge ccd_pixel_clk);
    {rgb_valid, bin_valid, erosion_valid, dilation_valid} = 4'b0000;
  endtask

  // Checked readout of every buffer word once
  task automatic check_frame(input int id);
    int seen;
    repeat (4) @(negedge ccd_pixel_clk);
    pix_test = id;
    check_en = 1'b1;
    seen = 0;
    while (seen < WORDS) begin
      @(negedge ccd_pixel_clk);
      if (vga_blank_n) seen++;
    end
    @(negedge ccd_pixel_clk);
    check_en = 1'b0;
  endtask

  task automatic wait_led_toggle(input int id);
    logic prev;
    int n;
    prev = pulse_led;
    n = 0;
    do begin
      @(negedge ccd_pixel_clk);
      n++;
    end while (pulse_led == prev && n <= `VID_RATE_WINDOW + 2);
    if (pulse_led == prev) begin
      test_err[id]++;
      $display("%s: pulse_led did not toggle within a rate window", tname[id]);
    end
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    int hs_falls, blank_cnt, vs_low, total;
    logic prev_hs;
    logic [7:0] first_byte;
    rst_n = 1'b0;
    stream_reset_n = 1'b1;
    view_sel = view_rgb;
    chan_en = 3'b011;
    rgb_red = '0;
    rgb_green = '0;
    rgb_blue = '0;
    binarized = '0;
    eroded = '0;
    dilated = '0;
    {rgb_valid, bin_valid, erosion_valid, dilation_valid} = 4'b0000;
    frame_start = 1'b0;
    check_en = 1'b0;
    model_clr = 1'b0;
    model_wr = 0;
    pix_test = 2;
    lcg_state = 32'h00c17a3a;
    foreach (test_err[i]) test_err[i] = 0;
    repeat (3) @(negedge ccd_pixel_clk);
    // Pins while still in reset
    check_eq(0, {1'b1, 1'b1, 1'b0, 1'b0}, {vga_hs, vga_vs, vga_blank_n, pulse_led});
    check_eq(0, 24'h0, {vga_r, vga_g, vga_b});
    check_eq(0, {seg_of(4'h0), seg_of(4'h0)}, {hex1, hex0});
    check_eq(0, 0, {UUT.u_fbuf.wr_addr, UUT.u_fbuf.rd_addr});
    rst_n = 1'b1;
    report_test(0);
    fork
      begin
        // One frame of raster counts on the pins
        wait_vs_fall();
        hs_falls = 0;
        blank_cnt = 0;
        vs_low = 0;
        prev_hs = vga_hs;
        repeat (FRAME_CYCLES) begin
          @(negedge ccd_pixel_clk);
          if (prev_hs && !vga_hs) hs_falls++;
          if (vga_blank_n) blank_cnt++;
          if (!vga_vs) vs_low++;
          prev_hs = vga_hs;
        end
        check_eq(1, `VID_V_TOTAL, hs_falls);
        check_eq(1, WORDS, blank_cnt);
        check_eq(1, `VID_V_SYNC * H_TOTAL, vs_low);
        report_test(1);
        // Rate meter over three windows
        wait_led_toggle(5);
        repeat (RATE_STROBES) begin
          @(negedge ccd_pixel_clk) frame_start = 1'b1;
          @(negedge ccd_pixel_clk) frame_start = 1'b0;
        end
        wait_led_toggle(5);
        check_eq(5, {seg_of(RATE_STROBES / 16), seg_of(RATE_STROBES % 16)}, {hex1, hex0});
        wait_led_toggle(5);
        check_eq(5, {seg_of(4'h0), seg_of(4'h0)}, {hex1, hex0});
        report_test(5);
      end
      begin
        write_frame(view_rgb, 1'b0);
        check_frame(2);
        report_test(2);
        for (int v = 1; v < 4; v++) begin
          view_sel = view_t'(v);
          write_frame(view_t'(v), 1'b1);
          check_frame(3);
        end
        report_test(3);
        // A few words so the write pointer leaves zero
        view_sel = view_binary;
        for (int i = 0; i < PRE_WORDS; i++) begin
          @(negedge ccd_pixel_clk);
          binarized = 8'h30 + 8'(i);
          bin_valid = 1'b1;
          ref_mem[model_wr] = {8'h00, binarized};
          model_wr = (model_wr + 1) % WORDS;
        end
        @(negedge ccd_pixel_clk);
        bin_valid = 1'b0;
        // Stream reset from the start of an active line, read pointer past zero
        while (vga_blank_n) @(negedge ccd_pixel_clk);
        while (!vga_blank_n) @(negedge ccd_pixel_clk);
        stream_reset_n = 1'b0;
        model_clr = 1'b1;
        repeat (2) @(negedge ccd_pixel_clk);
        check_eq(4, 0, {UUT.u_fbuf.wr_addr, UUT.u_fbuf.rd_addr});
        // Held into vertical blanking, next frame reads from address zero
        wait_vs_fall();
        stream_reset_n = 1'b1;
        model_clr = 1'b0;
        first_byte = 8'h5a;
        @(negedge ccd_pixel_clk);
        binarized = first_byte;
        bin_valid = 1'b1;
        ref_mem[0] = {8'h00, first_byte};
        model_wr = 1;
        @(negedge ccd_pixel_clk);
        bin_valid = 1'b0;
        while (!vga_blank_n) @(negedge ccd_pixel_clk);
        check_eq(4, {3{first_byte}}, {vga_r, vga_g, vga_b});
        report_test(4);
      end
    join
    total = 0;
    foreach (test_err[i]) total += test_err[i];
    $display("summary: %0d tests, %0d errors", NUM_TESTS, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(LIMIT_CYCLES * 40);
    $display("timeout: tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
src/vid_pkg.sv
src/vid_raster_if.sv
src/stream_pack.sv
src/frame_buffer.sv
src/vga_timing.sv
src/vga_pixel_out.sv
src/frame_rate_meter.sv
src/vid_capture_top.sv
sim/tb_vid_capture.sv

// File: Bender.yml
package:
  name: vid_capture

export_include_dirs:
  - include

sources:
  - src/vid_pkg.sv
  - src/vid_raster_if.sv
  - src/stream_pack.sv
  - src/frame_buffer.sv
  - src/vga_timing.sv
  - src/vga_pixel_out.sv
  - src/frame_rate_meter.sv
  - src/vid_capture_top.sv
  - target: simulation
    files:
      - sim/tb_vid_capture.sv
